// ==== hw/rv32i_bus_pkg.sv ====
`include "rv32i_settings.svh"

package rv32i_bus_pkg;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [`XLEN-1:0] adr;
        logic [3:0]       sel;
        logic [`XLEN-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [`XLEN-1:0] dat;
    } wb_rsp_t;

endpackage

// ==== hw/rv32i_core.sv ====
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module rv32i_core (
    input  logic                   clk,
    input  logic                   reset,
    output rv32i_bus_pkg::wb_req_t wb_req,
    input  rv32i_bus_pkg::wb_rsp_t wb_rsp
);

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem
    } state_e;

    state_e                state;
    logic [`XLEN-1:0]      pc;
    rv32i_isa_pkg::instr_t instr;
    rv32i_isa_pkg::ctrl_t  ctrl;
    logic [`XLEN-1:0]      imm;
    logic [`XLEN-1:0]      rs1_val;
    logic [`XLEN-1:0]      rs2_val;
    logic [`XLEN-1:0]      result;
    logic [`XLEN-1:0]      next_pc;
    logic [`XLEN-1:0]      mem_adr;
    logic [1:0]            byte_off;
    logic [3:0]            mem_sel;
    logic [`XLEN-1:0]      store_data;
    logic [`XLEN-1:0]      lane_data;
    logic [`XLEN-1:0]      load_val;
    logic [`XLEN-1:0]      rd_wdata;
    logic                  rd_we;
    logic                  mem_op;

    function automatic rv32i_bus_pkg::wb_req_t bus_req(input logic [`XLEN-1:0] addr,
                                                        input logic             write,
                                                        input logic [3:0]       lanes,
                                                        input logic [`XLEN-1:0] data);
        bus_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, sel: lanes, dat: data};
    endfunction

    rv32i_decoder u_decoder (
        .instruction (instr),
        .ctrl        (ctrl)
    );

    rv32i_imm_gen u_imm_gen (
        .instruction (instr),
        .imm_sel     (ctrl.imm_sel),
        .imm         (imm)
    );

    rv32i_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd     (ctrl.rd),
        .we     (rd_we),
        .wdata  (rd_wdata),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    rv32i_execute u_execute (
        .ctrl    (ctrl),
        .pc      (pc),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .imm     (imm),
        .result  (result),
        .next_pc (next_pc)
    );

    assign mem_op   = ctrl.mem_read || ctrl.mem_write;
    assign mem_adr  = {result[`XLEN-1:2], 2'b00}; // word aligned, lanes in sel
    assign byte_off = result[1:0];

    always_comb begin
        case (ctrl.mem_size[1:0])
            2'b00:   mem_sel = 4'b0001 << byte_off;
            2'b01:   mem_sel = 4'b0011 << byte_off;
            default: mem_sel = 4'b1111;
        endcase
    end

    assign store_data = rs2_val << {byte_off, 3'b000};
    assign lane_data  = wb_rsp.dat >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            3'b000:  load_val = {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
            3'b001:  load_val = {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
            3'b100:  load_val = {{(`XLEN-8){1'b0}}, lane_data[7:0]};
            3'b101:  load_val = {{(`XLEN-16){1'b0}}, lane_data[15:0]};
            default: load_val = lane_data;
        endcase
    end

    // alu ops write in exec, loads in their ack cycle
    assign rd_we    = ctrl.reg_we && ((state == st_exec && !mem_op) ||
                                      (state == st_mem && wb_rsp.ack));
    assign rd_wdata = ctrl.mem_read ? load_val : result;

    always_ff @(posedge clk) begin
        if (state == st_fetch && wb_req.stb && wb_rsp.ack) begin
            instr <= wb_rsp.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_fetch;
            pc         <= `RESET_PC;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!wb_req.stb) begin
                        wb_req <= bus_req(pc, 1'b0, 4'b1111, '0); // after reset or data access
                    end else if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        state      <= st_exec;
                    end
                end
                st_exec: begin
                    if (mem_op) begin
                        wb_req <= bus_req(mem_adr, ctrl.mem_write, mem_sel, store_data);
                        state  <= st_mem;
                    end else begin
                        pc     <= next_pc;
                        wb_req <= bus_req(next_pc, 1'b0, 4'b1111, '0);
                        state  <= st_fetch;
                    end
                end
                st_mem: begin
                    if (wb_rsp.ack) begin
                        pc         <= next_pc;
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        wb_req.we  <= 1'b0;
                        state      <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

endmodule

// ==== hw/rv32i_decoder.sv ====
`timescale 1ns/100ps

module rv32i_decoder (
    input  rv32i_isa_pkg::instr_t instruction,
    output rv32i_isa_pkg::ctrl_t  ctrl
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       alt;
    rv32i_isa_pkg::alu_op_e     arith_op;
    rv32i_isa_pkg::branch_sel_e cond;

    assign opcode = instruction.r.opcode;
    assign func3  = instruction.r.funct3;
    assign alt    = instruction.r.funct7[5]; // instruction bit 30

    always_comb begin
        case (func3)
            3'b000:  arith_op = (alt && opcode == rv32i_isa_pkg::op_reg) ?
                                rv32i_isa_pkg::alu_sub : rv32i_isa_pkg::alu_add;
            3'b001:  arith_op = rv32i_isa_pkg::alu_sll;
            3'b010:  arith_op = rv32i_isa_pkg::alu_slt;
            3'b011:  arith_op = rv32i_isa_pkg::alu_sltu;
            3'b100:  arith_op = rv32i_isa_pkg::alu_xor;
            3'b101:  arith_op = alt ? rv32i_isa_pkg::alu_sra : rv32i_isa_pkg::alu_srl;
            3'b110:  arith_op = rv32i_isa_pkg::alu_or;
            default: arith_op = rv32i_isa_pkg::alu_and;
        endcase
    end

    always_comb begin
        case (func3)
            3'b000:  cond = rv32i_isa_pkg::br_beq;
            3'b001:  cond = rv32i_isa_pkg::br_bne;
            3'b100:  cond = rv32i_isa_pkg::br_blt;
            3'b101:  cond = rv32i_isa_pkg::br_bge;
            3'b110:  cond = rv32i_isa_pkg::br_bltu;
            3'b111:  cond = rv32i_isa_pkg::br_bgeu;
            default: cond = rv32i_isa_pkg::br_none;
        endcase
    end

    always_comb begin
        ctrl.rs1        = instruction.r.rs1;
        ctrl.rs2        = instruction.r.rs2;
        ctrl.rd         = instruction.r.rd;
        ctrl.mem_size   = func3;
        ctrl.alu_op     = rv32i_isa_pkg::alu_add;
        ctrl.imm_sel    = rv32i_isa_pkg::imm_i;
        ctrl.branch_sel = rv32i_isa_pkg::br_none;
        ctrl.reg_we     = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.use_imm    = 1'b1;
        ctrl.use_pc_a   = 1'b0;
        ctrl.link       = 1'b0;
        case (opcode)
            rv32i_isa_pkg::op_reg: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b0;
                ctrl.alu_op  = arith_op;
            end
            rv32i_isa_pkg::op_imm: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = arith_op;
            end
            rv32i_isa_pkg::op_load: begin
                ctrl.reg_we   = 1'b1;
                ctrl.mem_read = 1'b1;
            end
            rv32i_isa_pkg::op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.imm_sel   = rv32i_isa_pkg::imm_s;
            end
            rv32i_isa_pkg::op_branch: begin
                ctrl.branch_sel = cond;
                ctrl.imm_sel    = rv32i_isa_pkg::imm_b;
                ctrl.use_pc_a   = 1'b1; // alu forms the target
            end
            rv32i_isa_pkg::op_lui: begin
                ctrl.reg_we  = 1'b1;
                ctrl.rs1     = 5'd0;
                ctrl.alu_op  = rv32i_isa_pkg::alu_pass_b;
                ctrl.imm_sel = rv32i_isa_pkg::imm_u;
            end
            rv32i_isa_pkg::op_auipc: begin
                ctrl.reg_we   = 1'b1;
                ctrl.use_pc_a = 1'b1;
                ctrl.imm_sel  = rv32i_isa_pkg::imm_u;
            end
            rv32i_isa_pkg::op_jal: begin
                ctrl.reg_we     = 1'b1;
                ctrl.link       = 1'b1;
                ctrl.use_pc_a   = 1'b1;
                ctrl.imm_sel    = rv32i_isa_pkg::imm_j;
                ctrl.branch_sel = rv32i_isa_pkg::br_jump;
            end
            rv32i_isa_pkg::op_jalr: begin
                ctrl.reg_we     = 1'b1;
                ctrl.link       = 1'b1;
                ctrl.branch_sel = rv32i_isa_pkg::br_jump;
            end
            default: ;  // fence, system: pc advance only
        endcase
    end

endmodule

// ==== hw/rv32i_execute.sv ====
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module rv32i_execute (
    input  rv32i_isa_pkg::ctrl_t ctrl,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     rs1_val,
    input  logic [`XLEN-1:0]     rs2_val,
    input  logic [`XLEN-1:0]     imm,
    output logic [`XLEN-1:0]     result,
    output logic [`XLEN-1:0]     next_pc
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] pc_plus4;
    logic [4:0]       shamt;
    logic             taken;

    assign op_a     = ctrl.use_pc_a ? pc : rs1_val;
    assign op_b     = ctrl.use_imm ? imm : rs2_val;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = pc + 'd4;

    always_comb begin
        case (ctrl.alu_op)
            rv32i_isa_pkg::alu_sub:    alu_out = op_a - op_b;
            rv32i_isa_pkg::alu_sll:    alu_out = op_a << shamt;
            rv32i_isa_pkg::alu_slt:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv32i_isa_pkg::alu_sltu:   alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
            rv32i_isa_pkg::alu_xor:    alu_out = op_a ^ op_b;
            rv32i_isa_pkg::alu_srl:    alu_out = op_a >> shamt;
            rv32i_isa_pkg::alu_sra:    alu_out = $signed(op_a) >>> shamt;
            rv32i_isa_pkg::alu_or:     alu_out = op_a | op_b;
            rv32i_isa_pkg::alu_and:    alu_out = op_a & op_b;
            rv32i_isa_pkg::alu_pass_b: alu_out = op_b;
            default:                   alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ctrl.branch_sel)
            rv32i_isa_pkg::br_beq:  taken = rs1_val == rs2_val;
            rv32i_isa_pkg::br_bne:  taken = rs1_val != rs2_val;
            rv32i_isa_pkg::br_blt:  taken = $signed(rs1_val) < $signed(rs2_val);
            rv32i_isa_pkg::br_bge:  taken = $signed(rs1_val) >= $signed(rs2_val);
            rv32i_isa_pkg::br_bltu: taken = rs1_val < rs2_val;
            rv32i_isa_pkg::br_bgeu: taken = rs1_val >= rs2_val;
            rv32i_isa_pkg::br_jump: taken = 1'b1;
            default:                taken = 1'b0;
        endcase
    end

    // target is pc+imm for branch and jal, rs1+imm for jalr
    assign next_pc = taken ? {alu_out[`XLEN-1:1], 1'b0} : pc_plus4;
    assign result  = ctrl.link ? pc_plus4 : alu_out;

endmodule

// ==== hw/rv32i_imm_gen.sv ====
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module rv32i_imm_gen (
    input  rv32i_isa_pkg::instr_t   instruction,
    input  rv32i_isa_pkg::imm_sel_e imm_sel,
    output logic [`XLEN-1:0]        imm
);

    always_comb begin
        case (imm_sel)
            rv32i_isa_pkg::imm_i:
                imm = {{(`XLEN-12){instruction.i.imm_11_0[11]}}, instruction.i.imm_11_0};
            rv32i_isa_pkg::imm_s:
                imm = {{(`XLEN-12){instruction.s.imm_11_5[6]}},
                       instruction.s.imm_11_5, instruction.s.imm_4_0};
            rv32i_isa_pkg::imm_b:
                imm = {{(`XLEN-12){instruction.b.imm_12}}, instruction.b.imm_11,
                       instruction.b.imm_10_5, instruction.b.imm_4_1, 1'b0};
            rv32i_isa_pkg::imm_u:
                imm = {instruction.u.imm_31_12, 12'h000};
            rv32i_isa_pkg::imm_j:
                imm = {{(`XLEN-20){instruction.j.imm_20}}, instruction.j.imm_19_12,
                       instruction.j.imm_11, instruction.j.imm_10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== hw/rv32i_isa_pkg.sv ====
package rv32i_isa_pkg;

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_fence  = 7'b0001111,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i, imm_s, imm_b, imm_u, imm_j
    } imm_sel_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jump
    } branch_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        alu_op_e     alu_op;
        imm_sel_e    imm_sel;
        branch_sel_e branch_sel;
        logic [2:0]  mem_size;     // func3 of loads and stores
        logic        reg_we;
        logic        mem_read;
        logic        mem_write;
        logic        use_imm;
        logic        use_pc_a;
        logic        link;
    } ctrl_t;

endpackage

// ==== hw/rv32i_regfile.sv ====
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module rv32i_regfile (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic             we,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// ==== hw/rv32i_settings.svh ====
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

`define XLEN      32
`define REG_COUNT 32
`define RESET_PC  32'h0000_0000

`endif

// ==== rv32i_core.f ====
+incdir+hw
hw/rv32i_isa_pkg.sv
hw/rv32i_bus_pkg.sv
hw/rv32i_decoder.sv
hw/rv32i_imm_gen.sv
hw/rv32i_regfile.sv
hw/rv32i_execute.sv
hw/rv32i_core.sv
tb/rv32i_tb_clock.sv
tb/rv32i_tb.sv

// ==== tb/rv32i_tb.sv ====
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module rv32i_tb;

    typedef struct packed {
        logic        st;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
        logic [31:0] npc;
    } ref_step_t;

    logic                   clk;
    logic                   reset;
    rv32i_bus_pkg::wb_req_t wb_req;
    rv32i_bus_pkg::wb_rsp_t wb_rsp;

    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    integer      seed = 32'hf7c92fb7;
    integer      errors = 0;
    integer      n = 0;
    integer      stores_seen = 0;
    logic        done = 1'b0;

    int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    int tk_a [6]  = '{1, 1, 1, 2, 2, 1};
    int tk_b [6]  = '{1, 2, 2, 1, 1, 2};
    int nt_a [6]  = '{1, 1, 2, 1, 1, 2};
    int nt_b [6]  = '{2, 1, 1, 2, 2, 1};

    rv32i_tb_clock u_clock (.clk(clk), .reset(reset));

    rv32i_core UUT (.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp));

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[n] = w;
        n++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // one model instruction with its store and next pc
    function automatic ref_step_t step_ref();
        ref_step_t   res;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] w;
        logic [31:0] wr;
        logic        we;
        logic        tk;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        ins   = ref_mem[ref_pc[9:2]];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        res     = '0;
        res.npc = ref_pc + 4;
        we      = 1'b0;
        wr      = '0;
        addr    = a + imm_i;
        case (ins[6:0])
            7'h33: begin
                we = 1;
                wr = alu(ins[14:12], ins[30], a, b);
            end
            7'h13: begin
                we = 1;
                wr = alu(ins[14:12], ins[30] && ins[14:12] == 5, a, imm_i);
            end
            7'h37: begin
                we = 1;
                wr = {ins[31:12], 12'h0};
            end
            7'h17: begin
                we = 1;
                wr = ref_pc + {ins[31:12], 12'h0};
            end
            7'h6f: begin
                we      = 1;
                wr      = ref_pc + 4;
                res.npc = ref_pc + imm_j;
            end
            7'h67: begin
                we      = 1;
                wr      = ref_pc + 4;
                res.npc = addr & ~32'd1;
            end
            7'h63: begin
                case (ins[14:12])
                    3'd0:    tk = a == b;
                    3'd1:    tk = a != b;
                    3'd4:    tk = $signed(a) < $signed(b);
                    3'd5:    tk = $signed(a) >= $signed(b);
                    3'd6:    tk = a < b;
                    default: tk = a >= b;
                endcase
                if (tk) res.npc = ref_pc + imm_b;
            end
            7'h03: begin
                we = 1;
                w  = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
                case (ins[14:12])
                    3'd0:    wr = {{24{w[7]}}, w[7:0]};
                    3'd1:    wr = {{16{w[15]}}, w[15:0]};
                    3'd4:    wr = {24'd0, w[7:0]};
                    3'd5:    wr = {16'd0, w[15:0]};
                    default: wr = w;
                endcase
            end
            7'h23: begin
                addr    = a + imm_s;
                res.st  = 1'b1;
                res.adr = {addr[31:2], 2'b00};
                res.sel = (ins[13:12] == 0) ? 4'b0001 << addr[1:0] :
                          (ins[13:12] == 1) ? 4'b0011 << addr[1:0] : 4'b1111;
                res.dat = b << (8 * addr[1:0]);
                w = ref_mem[addr[9:2]];
                for (int i = 0; i < 4; i++) begin
                    if (res.sel[i]) w[8*i +: 8] = res.dat[8*i +: 8];
                end
                ref_mem[addr[9:2]] = w;
            end
            default: ; // fence and system do nothing
        endcase
        if (we && ins[11:7] != 0) ref_regs[ins[11:7]] = wr;
        return res;
    endfunction

    initial begin
        wb_rsp = '0;
        for (int i = 0; i < 256; i++) mem[i] = 32'hA500_0000 | (i * 32'h0001_0101);
        emit(enc_i(-5, 0, 0, 1, 7'h13));             // x1 = -5
        emit(enc_i(7, 0, 0, 2, 7'h13));              // x2 = 7
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(7'h00, 2, 1, f, 3, 7'h33));
            emit(enc_s(32'h200, 3, 0, 2));
        end
        emit(enc_r(7'h20, 2, 1, 0, 3, 7'h33));       // sub
        emit(enc_s(32'h200, 3, 0, 2));
        emit(enc_r(7'h20, 2, 1, 5, 3, 7'h33));       // sra
        emit(enc_s(32'h200, 3, 0, 2));
        emit(enc_i(32'h403, 1, 5, 3, 7'h13));        // srai by 3
        emit(enc_s(32'h200, 3, 0, 2));
        emit(enc_i(-3, 1, 2, 3, 7'h13));             // slti
        emit(enc_s(32'h200, 3, 0, 2));
        emit({20'h12345, 5'd7, 7'h37});              // lui
        emit(enc_s(32'h204, 7, 0, 2));
        emit({20'h00001, 5'd8, 7'h17});              // auipc
        emit(enc_s(32'h204, 8, 0, 2));
        for (int k = 0; k < 6; k++) begin
            emit(enc_b(8, tk_b[k], tk_a[k], br_f3[k]));
            emit(enc_i(2 * k + 10, 0, 0, 9, 7'h13));
            emit(enc_s(32'h228, 9, 0, 2));
            emit(enc_b(8, nt_b[k], nt_a[k], br_f3[k]));
            emit(enc_i(2 * k + 11, 0, 0, 9, 7'h13));
            emit(enc_s(32'h228, 9, 0, 2));
        end
        emit(enc_j(8, 10));                          // jal over the marker
        emit(enc_i(98, 0, 0, 9, 7'h13));
        emit(enc_s(32'h22C, 10, 0, 2));
        emit(enc_s(32'h22C, 9, 0, 2));
        emit({20'h0, 5'd11, 7'h17});
        emit(enc_i(12, 11, 0, 12, 7'h67));           // jalr past the marker
        emit(enc_i(99, 0, 0, 9, 7'h13));
        emit(enc_s(32'h22C, 12, 0, 2));
        emit(enc_s(32'h22C, 9, 0, 2));
        emit(enc_i(32'h678, 7, 0, 13, 7'h13));       // x13 = 0x12345678
        for (int o = 0; o < 4; o++) emit(enc_s(32'h210 + o, o < 2 ? 13 : 1, 0, 0));
        emit(enc_s(32'h214, 1, 0, 1));
        emit(enc_s(32'h216, 13, 0, 1));
        emit(enc_s(32'h218, 13, 0, 2));
        for (int o = 0; o < 4; o++) begin
            emit(enc_i(32'h210 + o, 0, 0, 14, 7'h03));
            emit(enc_s(32'h220, 14, 0, 2));
            emit(enc_i(32'h210 + o, 0, 4, 14, 7'h03));
            emit(enc_s(32'h220, 14, 0, 2));
        end
        for (int o = 0; o < 4; o += 2) begin
            emit(enc_i(32'h214 + o, 0, 1, 14, 7'h03));
            emit(enc_s(32'h220, 14, 0, 2));
            emit(enc_i(32'h214 + o, 0, 5, 14, 7'h03));
            emit(enc_s(32'h220, 14, 0, 2));
        end
        emit(enc_i(32'h218, 0, 2, 14, 7'h03));
        emit(enc_s(32'h220, 14, 0, 2));
        emit(enc_i(5, 0, 0, 0, 7'h13));              // write to x0
        emit(32'h0000_000F);                         // fence
        emit(enc_s(32'h224, 0, 0, 2));
        emit(enc_i(1, 0, 0, 15, 7'h13));
        emit(enc_s(32'h3FC, 15, 0, 2));              // end marker
        emit(enc_j(0, 0));
        for (int i = 0; i < 256; i++) ref_mem[i] = mem[i];
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        ref_pc = `RESET_PC;
    end

    // slave memory, response changes on the falling edge
    always @(negedge clk) begin : memory_model
        logic [31:0] word;
        integer      waits;
        if (reset) begin
            wb_rsp.ack <= 1'b0;
            waits = -1;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (waits < 0) waits = $random(seed) & 3;
            if (waits == 0) begin
                word = mem[wb_req.adr[9:2]];
                if (wb_req.we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_req.sel[i]) word[8*i +: 8] = wb_req.dat[8*i +: 8];
                    end
                    mem[wb_req.adr[9:2]] = word;
                end
                wb_rsp.dat <= word;
                wb_rsp.ack <= 1'b1;
                waits = -1;
            end else begin
                waits = waits - 1;
            end
        end
    end

    always @(posedge clk) begin : compare_stores
        ref_step_t res;
        logic      found;
        integer    steps;
        if (!reset && wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
            found = 1'b0;
            steps = 0;
            while (!found && steps < 400) begin
                res    = step_ref();
                ref_pc = res.npc;
                steps++;
                found  = res.st;
            end
            if (!found) begin
                errors++;
                $display("reference model made no store within 400 instructions");
            end else begin
                check_value("wb_req.adr", wb_req.adr, res.adr);
                check_value("wb_req.sel", {28'd0, wb_req.sel}, {28'd0, res.sel});
                check_value("wb_req.dat", wb_req.dat, res.dat);
            end
            stores_seen++;
            if (wb_req.adr == 32'h3FC) done = 1'b1;
        end
    end

    initial begin : main
        integer cycles;
        cycles = 0;
        while (reset && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            errors++;
            $display("timeout: reset was never released");
        end
        cycles = 0;
        while (!done && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("timeout: the program never reached its final store");
        end
        $display("stores checked: %0d, errors: %0d", stores_seen, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/rv32i_tb_clock.sv ====
`timescale 1ns/100ps

module rv32i_tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule
